/* rtl/ooo_config.svh */
`ifndef OOO_CONFIG_SVH
`define OOO_CONFIG_SVH

////////////////////////////////////////////////////////////////////////////
// Core dimensions
////////////////////////////////////////////////////////////////////////////

// Data path width
`define XLEN        32

// Architectural registers x0..x31
`define ARCH_REGS   32

// Physical registers of which half start out free
`define PHYS_REGS   64

`define ROB_DEPTH   16

`endif

/* rtl/ooo_pkg.sv */
`include "ooo_config.svh"

package ooo_pkg;

    typedef logic [`XLEN-1:0]                word_t;
    typedef logic [$clog2(`ARCH_REGS)-1:0]   arch_reg_t;
    typedef logic [$clog2(`PHYS_REGS)-1:0]   phys_reg_t;
    typedef logic [$clog2(`ROB_DEPTH)-1:0]   rob_idx_t;

    // RV32I major opcodes handled by the core
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111
    } opcode_e;

    typedef enum logic [3:0] {
        ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, SLT, SLTU, PASS_B
    } alu_op_e;

    typedef struct packed {
        word_t     pc;
        word_t     instr;
    } fetch_t;

    typedef struct packed {
        word_t     pc;
        alu_op_e   alu_op;
        arch_reg_t rs1;
        arch_reg_t rs2;
        arch_reg_t rd;
        logic      has_imm;
        word_t     imm;
        logic      writes_rd;
    } decoded_t;

    typedef struct packed {
        alu_op_e   alu_op;
        phys_reg_t phys_rs1;
        phys_reg_t phys_rs2;
        phys_reg_t phys_rd;
        logic      has_imm;
        word_t     imm;
        logic      writes_rd;
        rob_idx_t  rob_idx;
    } renamed_t;

    // Old mapping is kept so it can be freed at retirement
    typedef struct packed {
        word_t     pc;
        arch_reg_t rd;
        logic      writes_rd;
        phys_reg_t phys_rd;
        phys_reg_t old_phys_rd;
    } rob_alloc_t;

    typedef struct packed {
        rob_idx_t  rob_idx;
        phys_reg_t phys_rd;
        logic      writes_rd;
        word_t     value;
    } complete_t;

    typedef struct packed {
        word_t     pc;
        arch_reg_t rd;
        logic      writes_rd;
        word_t     value;
    } retire_t;

endpackage

/* rtl/rv_decoder.sv */
`timescale 1ns/10ps

module rv_decoder import ooo_pkg::*; (
    input  logic     clk,
    input  logic     rstn,
    input  logic     in_valid,
    output logic     in_ready,
    input  fetch_t   in,
    output logic     out_valid,
    input  logic     out_ready,
    output decoded_t out
);

    opcode_e    opcode;
    logic [2:0] funct3;
    logic       alt;
    decoded_t   dec;

    assign opcode = opcode_e'(in.instr[6:0]);
    assign funct3 = in.instr[14:12];
    // Bit 30 picks SUB over ADD and SRA over SRL
    assign alt    = in.instr[30];

    always_comb begin
        dec.pc        = in.pc;
        dec.alu_op    = ADD;
        dec.rs1       = in.instr[19:15];
        dec.rs2       = in.instr[24:20];
        dec.rd        = in.instr[11:7];
        dec.has_imm   = 1'b0;
        dec.imm       = {{20{in.instr[31]}}, in.instr[31:20]};
        dec.writes_rd = 1'b0;
        case (opcode)
            OP, OP_IMM: begin
                dec.has_imm   = (opcode == OP_IMM);
                dec.writes_rd = (dec.rd != '0);
                case (funct3)
                    3'b000: dec.alu_op = (opcode == OP && alt) ? SUB : ADD;
                    3'b001: dec.alu_op = SLL;
                    3'b010: dec.alu_op = SLT;
                    3'b011: dec.alu_op = SLTU;
                    3'b100: dec.alu_op = XOR;
                    3'b101: dec.alu_op = alt ? SRA : SRL;
                    3'b110: dec.alu_op = OR;
                    default: dec.alu_op = AND;
                endcase
            end
            LUI: begin
                dec.alu_op    = PASS_B;
                dec.has_imm   = 1'b1;
                dec.imm       = {in.instr[31:12], 12'b0};
                dec.rs1       = '0;
                dec.writes_rd = (dec.rd != '0);
            end
            default: begin
                // Unknown opcode reads x0 only and never writes
                dec.has_imm = 1'b1;
                dec.rs1     = '0;
                dec.rs2     = '0;
            end
        endcase
    end

    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out <= dec;
        end
    end

endmodule

/* rtl/rename_unit.sv */
`timescale 1ns/10ps
`include "ooo_config.svh"

module rename_unit import ooo_pkg::*; (
    input  logic       clk,
    input  logic       rstn,
    input  logic       in_valid,
    output logic       in_ready,
    input  decoded_t   in,
    output logic       out_valid,
    input  logic       out_ready,
    output renamed_t   out,
    output logic       rob_valid,
    input  logic       rob_ready,
    output rob_alloc_t rob_alloc,
    input  rob_idx_t   rob_tail,
    output logic       alloc_valid,
    output phys_reg_t  alloc_phys,
    input  logic       free_valid,
    input  phys_reg_t  free_phys
);

    localparam int FREE_DEPTH = `PHYS_REGS - `ARCH_REGS;

    phys_reg_t rename_table [`ARCH_REGS];
    phys_reg_t free_q [FREE_DEPTH];
    logic [$clog2(FREE_DEPTH)-1:0] free_head;
    logic [$clog2(FREE_DEPTH)-1:0] free_tail;
    logic [$clog2(FREE_DEPTH):0]   free_count;

    logic       valid_q;
    logic       fire;
    logic       accept;
    renamed_t   ren_d;
    renamed_t   ren_q;
    rob_alloc_t alloc_d;

    // Hand-off needs issue and ROB in the same cycle
    assign fire      = valid_q && out_ready && rob_ready;
    assign out_valid = valid_q && rob_ready;
    assign rob_valid = valid_q && out_ready;

    assign in_ready    = (!valid_q || fire) && (!in.writes_rd || free_count != '0);
    assign accept      = in_valid && in_ready;
    assign alloc_valid = accept && in.writes_rd;
    assign alloc_phys  = free_q[free_head];

    always_comb begin
        ren_d.alu_op      = in.alu_op;
        ren_d.phys_rs1    = rename_table[in.rs1];
        ren_d.phys_rs2    = rename_table[in.rs2];
        ren_d.phys_rd     = in.writes_rd ? alloc_phys : '0;
        ren_d.has_imm     = in.has_imm;
        ren_d.imm         = in.imm;
        ren_d.writes_rd   = in.writes_rd;
        ren_d.rob_idx     = '0;
        alloc_d.pc          = in.pc;
        alloc_d.rd          = in.rd;
        alloc_d.writes_rd   = in.writes_rd;
        alloc_d.phys_rd     = ren_d.phys_rd;
        alloc_d.old_phys_rd = in.writes_rd ? rename_table[in.rd] : '0;
    end

    // ROB slot is the tail at the moment of hand-off
    always_comb begin
        out         = ren_q;
        out.rob_idx = rob_tail;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_q    <= 1'b0;
            free_head  <= '0;
            free_tail  <= '0;
            free_count <= FREE_DEPTH[$clog2(FREE_DEPTH):0];
            for (int i = 0; i < `ARCH_REGS; i++) begin
                rename_table[i] <= phys_reg_t'(i);
            end
            for (int i = 0; i < FREE_DEPTH; i++) begin
                free_q[i] <= phys_reg_t'(`ARCH_REGS + i);
            end
        end else begin
            if (accept) begin
                valid_q <= 1'b1;
            end else if (fire) begin
                valid_q <= 1'b0;
            end
            if (alloc_valid) begin
                rename_table[in.rd] <= alloc_phys;
                free_head           <= free_head + 1'b1;
            end
            if (free_valid) begin
                free_q[free_tail] <= free_phys;
                free_tail         <= free_tail + 1'b1;
            end
            free_count <= free_count + free_valid - alloc_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ren_q     <= ren_d;
            rob_alloc <= alloc_d;
        end
    end

endmodule

/* rtl/phys_reg_file.sv */
`timescale 1ns/10ps
`include "ooo_config.svh"

module phys_reg_file import ooo_pkg::*; (
    input  logic      clk,
    input  logic      rstn,
    input  phys_reg_t rs1,
    input  phys_reg_t rs2,
    output word_t     rs1_value,
    output word_t     rs2_value,
    output logic      rs1_ready,
    output logic      rs2_ready,
    input  logic      alloc_valid,
    input  phys_reg_t alloc_phys,
    input  logic      complete_valid,
    input  complete_t complete
);

    word_t                 regs [`PHYS_REGS];
    logic [`PHYS_REGS-1:0] ready;

    assign rs1_value = regs[rs1];
    assign rs2_value = regs[rs2];
    assign rs1_ready = ready[rs1];
    assign rs2_ready = ready[rs2];

    // Initial mapping is identity, so every register starts at zero
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ready <= '1;
            for (int i = 0; i < `PHYS_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            // A freshly allocated register is never the one completing
            if (alloc_valid) begin
                ready[alloc_phys] <= 1'b0;
            end
            if (complete_valid && complete.writes_rd) begin
                regs[complete.phys_rd]  <= complete.value;
                ready[complete.phys_rd] <= 1'b1;
            end
        end
    end

endmodule

/* rtl/issue_execute.sv */
`timescale 1ns/10ps

module issue_execute import ooo_pkg::*; (
    input  logic      clk,
    input  logic      rstn,
    input  logic      in_valid,
    output logic      in_ready,
    input  renamed_t  in,
    output phys_reg_t rs1,
    output phys_reg_t rs2,
    input  word_t     rs1_value,
    input  word_t     rs2_value,
    input  logic      rs1_ready,
    input  logic      rs2_ready,
    output logic      complete_valid,
    output complete_t complete
);

    renamed_t hold;
    logic     busy;
    logic     ops_ready;
    logic     fire;
    word_t    op_b;
    word_t    result;

    assign rs1 = hold.phys_rs1;
    assign rs2 = hold.phys_rs2;

    // Immediate forms only wait on rs1
    assign ops_ready = rs1_ready && (hold.has_imm || rs2_ready);
    assign fire      = busy && ops_ready;
    assign in_ready  = !busy || fire;

    assign op_b = hold.has_imm ? hold.imm : rs2_value;

    always_comb begin
        case (hold.alu_op)
            ADD:     result = rs1_value + op_b;
            SUB:     result = rs1_value - op_b;
            AND:     result = rs1_value & op_b;
            OR:      result = rs1_value | op_b;
            XOR:     result = rs1_value ^ op_b;
            SLL:     result = rs1_value << op_b[4:0];
            SRL:     result = rs1_value >> op_b[4:0];
            SRA:     result = word_t'($signed(rs1_value) >>> op_b[4:0]);
            SLT:     result = word_t'($signed(rs1_value) < $signed(op_b));
            SLTU:    result = word_t'(rs1_value < op_b);
            PASS_B:  result = op_b;
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            busy           <= 1'b0;
            complete_valid <= 1'b0;
        end else begin
            complete_valid <= fire;
            if (in_ready) begin
                busy <= in_valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            hold <= in;
        end
        if (fire) begin
            complete.rob_idx   <= hold.rob_idx;
            complete.phys_rd   <= hold.phys_rd;
            complete.writes_rd <= hold.writes_rd;
            complete.value     <= result;
        end
    end

endmodule

/* rtl/reorder_buffer.sv */
`timescale 1ns/10ps
`include "ooo_config.svh"

module reorder_buffer import ooo_pkg::*; (
    input  logic       clk,
    input  logic       rstn,
    input  logic       alloc_valid,
    output logic       alloc_ready,
    input  rob_alloc_t alloc,
    output rob_idx_t   tail,
    input  logic       complete_valid,
    input  complete_t  complete,
    output logic       retire_valid,
    input  logic       retire_ready,
    output retire_t    retire,
    output logic       free_valid,
    output phys_reg_t  free_phys
);

    rob_alloc_t entry [`ROB_DEPTH];
    word_t      value [`ROB_DEPTH];
    logic [`ROB_DEPTH-1:0] done;

    rob_idx_t                     head;
    logic [$clog2(`ROB_DEPTH):0]  count;
    logic                         push;
    logic                         pop;

    assign alloc_ready = (count != `ROB_DEPTH);
    assign push        = alloc_valid && alloc_ready;

    ////////////////////////////////////////////////////////////////////////////
    // Retirement from the head
    ////////////////////////////////////////////////////////////////////////////

    assign retire_valid = (count != '0) && done[head];
    assign pop          = retire_valid && retire_ready;

    assign retire.pc        = entry[head].pc;
    assign retire.rd        = entry[head].rd;
    assign retire.writes_rd = entry[head].writes_rd;
    // Non-writing instructions report zero
    assign retire.value     = entry[head].writes_rd ? value[head] : '0;

    // Previous mapping of rd goes back to the free list
    assign free_valid = pop && entry[head].writes_rd;
    assign free_phys  = entry[head].old_phys_rd;

    ////////////////////////////////////////////////////////////////////////////
    // Pointers and done bits
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            done  <= '0;
        end else begin
            if (push) begin
                done[tail] <= 1'b0;
                tail       <= tail + 1'b1;
            end
            if (complete_valid) begin
                done[complete.rob_idx] <= 1'b1;
            end
            if (pop) begin
                head <= head + 1'b1;
            end
            count <= count + push - pop;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entry[tail] <= alloc;
        end
        if (complete_valid) begin
            value[complete.rob_idx] <= complete.value;
        end
    end

endmodule

/* rtl/ooo_core.sv */
`timescale 1ns/10ps

module ooo_core import ooo_pkg::*; (
    input  logic    clk,
    input  logic    rstn,
    input  logic    fetch_valid,
    output logic    fetch_ready,
    input  fetch_t  fetch,
    output logic    retire_valid,
    input  logic    retire_ready,
    output retire_t retire
);

    logic       dec_valid;
    logic       dec_ready;
    decoded_t   dec;

    logic       ren_valid;
    logic       ren_ready;
    renamed_t   ren;
    logic       rob_valid;
    logic       rob_ready;
    rob_alloc_t rob_alloc;
    rob_idx_t   rob_tail;

    logic       alloc_valid;
    phys_reg_t  alloc_phys;
    logic       free_valid;
    phys_reg_t  free_phys;

    phys_reg_t  rs1;
    phys_reg_t  rs2;
    word_t      rs1_value;
    word_t      rs2_value;
    logic       rs1_ready;
    logic       rs2_ready;

    logic       complete_valid;
    complete_t  complete;

    ////////////////////////////////////////////////////////////////////////////
    // Front end
    ////////////////////////////////////////////////////////////////////////////

    rv_decoder u_decoder (
        .clk       (clk),
        .rstn      (rstn),
        .in_valid  (fetch_valid),
        .in_ready  (fetch_ready),
        .in        (fetch),
        .out_valid (dec_valid),
        .out_ready (dec_ready),
        .out       (dec)
    );

    rename_unit u_rename (
        .clk         (clk),
        .rstn        (rstn),
        .in_valid    (dec_valid),
        .in_ready    (dec_ready),
        .in          (dec),
        .out_valid   (ren_valid),
        .out_ready   (ren_ready),
        .out         (ren),
        .rob_valid   (rob_valid),
        .rob_ready   (rob_ready),
        .rob_alloc   (rob_alloc),
        .rob_tail    (rob_tail),
        .alloc_valid (alloc_valid),
        .alloc_phys  (alloc_phys),
        .free_valid  (free_valid),
        .free_phys   (free_phys)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Execute and retire
    ////////////////////////////////////////////////////////////////////////////

    phys_reg_file u_prf (
        .clk            (clk),
        .rstn           (rstn),
        .rs1            (rs1),
        .rs2            (rs2),
        .rs1_value      (rs1_value),
        .rs2_value      (rs2_value),
        .rs1_ready      (rs1_ready),
        .rs2_ready      (rs2_ready),
        .alloc_valid    (alloc_valid),
        .alloc_phys     (alloc_phys),
        .complete_valid (complete_valid),
        .complete       (complete)
    );

    issue_execute u_execute (
        .clk            (clk),
        .rstn           (rstn),
        .in_valid       (ren_valid),
        .in_ready       (ren_ready),
        .in             (ren),
        .rs1            (rs1),
        .rs2            (rs2),
        .rs1_value      (rs1_value),
        .rs2_value      (rs2_value),
        .rs1_ready      (rs1_ready),
        .rs2_ready      (rs2_ready),
        .complete_valid (complete_valid),
        .complete       (complete)
    );

    reorder_buffer u_rob (
        .clk            (clk),
        .rstn           (rstn),
        .alloc_valid    (rob_valid),
        .alloc_ready    (rob_ready),
        .alloc          (rob_alloc),
        .tail           (rob_tail),
        .complete_valid (complete_valid),
        .complete       (complete),
        .retire_valid   (retire_valid),
        .retire_ready   (retire_ready),
        .retire         (retire),
        .free_valid     (free_valid),
        .free_phys      (free_phys)
    );

endmodule

/* testbench/tb_program.svh */
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// Columns of add_row are instruction word, rd, writes_rd and retired value
task automatic load_program();
    // Register forms reading sources written one instruction earlier
    add_row(enc_itype(12'h005, 5'd0, 3'b000, 5'd1), 5'd1, 1'b1, 32'h0000_0005);
    add_row(enc_itype(12'hFFD, 5'd0, 3'b000, 5'd2), 5'd2, 1'b1, 32'hFFFF_FFFD);
    add_row(enc_rtype(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), 5'd3, 1'b1, 32'h0000_0002);
    add_row(enc_rtype(7'h20, 5'd2, 5'd1, 3'b000, 5'd4), 5'd4, 1'b1, 32'h0000_0008);
    add_row(enc_rtype(7'h00, 5'd2, 5'd1, 3'b111, 5'd5), 5'd5, 1'b1, 32'h0000_0005);
    add_row(enc_rtype(7'h00, 5'd2, 5'd1, 3'b110, 5'd6), 5'd6, 1'b1, 32'hFFFF_FFFD);
    add_row(enc_rtype(7'h00, 5'd2, 5'd1, 3'b100, 5'd7), 5'd7, 1'b1, 32'hFFFF_FFF8);
    add_row(enc_rtype(7'h00, 5'd3, 5'd1, 3'b001, 5'd8), 5'd8, 1'b1, 32'h0000_0014);
    add_row(enc_rtype(7'h00, 5'd3, 5'd2, 3'b101, 5'd9), 5'd9, 1'b1, 32'h3FFF_FFFF);
    add_row(enc_rtype(7'h20, 5'd3, 5'd2, 3'b101, 5'd10), 5'd10, 1'b1, 32'hFFFF_FFFF);
    add_row(enc_rtype(7'h00, 5'd1, 5'd2, 3'b010, 5'd11), 5'd11, 1'b1, 32'h0000_0001);
    add_row(enc_rtype(7'h00, 5'd1, 5'd2, 3'b011, 5'd12), 5'd12, 1'b1, 32'h0000_0000);

    // LUI and immediate forms
    add_row(enc_utype(20'h12345, 5'd13), 5'd13, 1'b1, 32'h1234_5000);
    add_row(enc_itype(12'h678, 5'd13, 3'b110, 5'd14), 5'd14, 1'b1, 32'h1234_5678);
    add_row(enc_itype(12'hFFF, 5'd14, 3'b100, 5'd15), 5'd15, 1'b1, 32'hEDCB_A987);
    add_row(enc_itype(12'h0FF, 5'd15, 3'b111, 5'd16), 5'd16, 1'b1, 32'h0000_0087);
    add_row(enc_itype(12'h004, 5'd1, 3'b001, 5'd17), 5'd17, 1'b1, 32'h0000_0050);
    add_row(enc_itype(12'h00C, 5'd13, 3'b101, 5'd18), 5'd18, 1'b1, 32'h0001_2345);
    add_row(enc_itype(12'h401, 5'd2, 3'b101, 5'd19), 5'd19, 1'b1, 32'hFFFF_FFFE);
    add_row(enc_itype(12'h000, 5'd2, 3'b010, 5'd20), 5'd20, 1'b1, 32'h0000_0001);
    add_row(enc_itype(12'h006, 5'd1, 3'b011, 5'd21), 5'd21, 1'b1, 32'h0000_0001);

    // x0 as destination and as source
    add_row(enc_rtype(7'h00, 5'd1, 5'd1, 3'b000, 5'd0), 5'd0, 1'b0, 32'h0);
    add_row(enc_rtype(7'h00, 5'd1, 5'd0, 3'b000, 5'd22), 5'd22, 1'b1, 32'h0000_0005);
    add_row(enc_itype(12'h001, 5'd22, 3'b000, 5'd24), 5'd24, 1'b1, 32'h0000_0006);

    // Load word, branch word, LUI to x0
    add_row({12'h000, 5'd2, 3'b010, 5'd23, 7'b0000011}, 5'd23, 1'b0, 32'h0);
    add_row(32'h0020_8463, 5'd8, 1'b0, 32'h0);
    add_row(enc_utype(20'hABCDE, 5'd0), 5'd0, 1'b0, 32'h0);

    // 72 writes to x25 and x26 outnumber the physical registers
    for (int k = 1; k <= 36; k++) begin
        add_row(enc_itype(12'h003, 5'd25, 3'b000, 5'd25), 5'd25, 1'b1, 3 * k);
        add_row(enc_rtype(7'h00, 5'd25, 5'd26, 3'b000, 5'd26), 5'd26, 1'b1,
                3 * k * (k + 1) / 2);
    end
endtask

`endif

/* testbench/tb_ooo_core.sv */
`timescale 1ns/10ps

module tb_ooo_core import ooo_pkg::*; ();

    localparam int MAX_ROWS   = 128;
    localparam int CLK_PERIOD = 100;

    typedef struct packed {
        fetch_t  req;
        retire_t exp;
    } prog_row_t;

    logic        clk;
    logic        rstn;
    logic        fetch_valid;
    logic        fetch_ready;
    fetch_t      fetch;
    logic        retire_valid;
    logic        retire_ready;
    retire_t     retire;

    prog_row_t   rows [MAX_ROWS];
    int          num_rows;
    int          retired;
    int          retire_errors;
    int          table_errors;
    int          other_errors;
    logic        loaded;
    integer      seed = 38;
    logic [31:0] arch_x [32];

    ooo_core UUT (
        .clk          (clk),
        .rstn         (rstn),
        .fetch_valid  (fetch_valid),
        .fetch_ready  (fetch_ready),
        .fetch        (fetch),
        .retire_valid (retire_valid),
        .retire_ready (retire_ready),
        .retire       (retire)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Instruction encoding and program table
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] enc_rtype(input logic [6:0] f7, input logic [4:0] rs2,
                                              input logic [4:0] rs1, input logic [2:0] f3,
                                              input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_itype(input logic [11:0] imm, input logic [4:0] rs1,
                                              input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] enc_utype(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, 7'b0110111};
    endfunction

    task automatic add_row(input logic [31:0] instr, input logic [4:0] rd, input logic wr,
                           input logic [31:0] value);
        rows[num_rows].req.pc        = 32'h1000 + 4 * num_rows;
        rows[num_rows].req.instr     = instr;
        rows[num_rows].exp.pc        = 32'h1000 + 4 * num_rows;
        rows[num_rows].exp.rd        = rd;
        rows[num_rows].exp.writes_rd = wr;
        rows[num_rows].exp.value     = value;
        num_rows++;
    endtask

    `include "tb_program.svh"

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("[ERROR] %0t ns %s expected %h got %h", $time, name, expected, actual);
    endtask

    task automatic print_counts();
        $display("Errors: %0d retire, %0d table, %0d other; %0d of %0d retired",
                 retire_errors, table_errors, other_errors, retired, num_rows);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Architectural reference model
    ////////////////////////////////////////////////////////////////////////////

    task automatic model_step(input logic [31:0] instr, output logic [4:0] rd,
                              output logic wr, output logic [31:0] val);
        logic [31:0] a;
        logic [31:0] b;
        rd  = instr[11:7];
        wr  = 1'b0;
        val = '0;
        a   = arch_x[instr[19:15]];
        b   = (instr[6:0] == 7'b0010011) ? {{20{instr[31]}}, instr[31:20]}
                                         : arch_x[instr[24:20]];
        if (instr[6:0] == 7'b0110011 || instr[6:0] == 7'b0010011) begin
            wr = 1'b1;
            case (instr[14:12])
                3'b000: val = (instr[6:0] == 7'b0110011 && instr[30]) ? a - b : a + b;
                3'b001: val = a << b[4:0];
                3'b010: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                3'b011: val = (a < b) ? 32'd1 : 32'd0;
                3'b100: val = a ^ b;
                3'b101: begin
                    if (instr[30])
                        val = $signed(a) >>> b[4:0];
                    else
                        val = a >> b[4:0];
                end
                3'b110: val = a | b;
                default: val = a & b;
            endcase
        end else if (instr[6:0] == 7'b0110111) begin
            wr  = 1'b1;
            val = {instr[31:12], 12'b0};
        end
        // x0 is never written and always reads zero
        if (rd == 5'd0) begin
            wr  = 1'b0;
            val = '0;
        end
        if (wr) begin
            arch_x[rd] = val;
        end
    endtask

    task automatic check_table();
        logic [4:0]  rd;
        logic        wr;
        logic [31:0] val;
        for (int i = 0; i < 32; i++) begin
            arch_x[i] = '0;
        end
        for (int i = 0; i < num_rows; i++) begin
            model_step(rows[i].req.instr, rd, wr, val);
            if (rows[i].exp.rd !== rd) begin
                report_mismatch($sformatf("rows[%0d].rd", i), rd, rows[i].exp.rd);
                table_errors++;
            end
            if (rows[i].exp.writes_rd !== wr) begin
                report_mismatch($sformatf("rows[%0d].writes_rd", i), wr, rows[i].exp.writes_rd);
                table_errors++;
            end
            if (rows[i].exp.value !== val) begin
                report_mismatch($sformatf("rows[%0d].value", i), val, rows[i].exp.value);
                table_errors++;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Drivers and retire checker
    ////////////////////////////////////////////////////////////////////////////

    // fetch_ready comes from registered state and holds until the rising edge
    task automatic feed_program();
        int i;
        i = 0;
        while (i < num_rows) begin
            @(negedge clk);
            fetch_valid = 1'b1;
            fetch       = rows[i].req;
            if (fetch_ready) begin
                i++;
            end
        end
        @(negedge clk);
        fetch_valid = 1'b0;
        fetch       = '0;
    endtask

    task automatic check_retire();
        retire_t exp;
        if (retired >= num_rows) begin
            $display("Extra retirement at %0t ns with pc %h after the last instruction",
                     $time, retire.pc);
            other_errors++;
        end else begin
            exp = rows[retired].exp;
            if (retire.pc !== exp.pc) begin
                report_mismatch("retire.pc", exp.pc, retire.pc);
                retire_errors++;
            end
            if (retire.rd !== exp.rd) begin
                report_mismatch("retire.rd", exp.rd, retire.rd);
                retire_errors++;
            end
            if (retire.writes_rd !== exp.writes_rd) begin
                report_mismatch("retire.writes_rd", exp.writes_rd, retire.writes_rd);
                retire_errors++;
            end
            if (retire.value !== exp.value) begin
                report_mismatch("retire.value", exp.value, retire.value);
                retire_errors++;
            end
        end
        retired++;
    endtask

    // Random back-pressure that is low about a third of the time
    initial begin
        wait (rstn === 1'b1);
        forever begin
            @(negedge clk);
            retire_ready = ($unsigned($random(seed)) % 3) != 0;
            if (retire_valid && retire_ready) begin
                check_retire();
            end
        end
    end

    initial begin
        wait (loaded === 1'b1);
        #((num_rows * 20 + 10) * CLK_PERIOD);
        $display("Timeout: a retirement is missing after %0d of %0d instructions",
                 retired, num_rows);
        print_counts();
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        rstn          = 1'b0;
        fetch_valid   = 1'b0;
        fetch         = '0;
        retire_ready  = 1'b0;
        num_rows      = 0;
        retired       = 0;
        retire_errors = 0;
        table_errors  = 0;
        other_errors  = 0;
        loaded        = 1'b0;
        load_program();
        check_table();
        loaded = 1'b1;

        repeat (2) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);
        if (retire_valid !== 1'b0) begin
            report_mismatch("retire_valid", 32'd0, 32'(retire_valid));
            other_errors++;
        end
        if (fetch_ready !== 1'b1) begin
            report_mismatch("fetch_ready", 32'd1, 32'(fetch_ready));
            other_errors++;
        end

        feed_program();
        wait (retired >= num_rows);
        // Watch a little longer for duplicated retirements
        repeat (20) @(negedge clk);

        print_counts();
        if (retire_errors + table_errors + other_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+rtl
+incdir+testbench
rtl/ooo_pkg.sv
rtl/rv_decoder.sv
rtl/rename_unit.sv
rtl/phys_reg_file.sv
rtl/issue_execute.sv
rtl/reorder_buffer.sv
rtl/ooo_core.sv
testbench/tb_ooo_core.sv

/* Bender.yml */
package:
  name: ooo_core

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/ooo_pkg.sv
      - rtl/rv_decoder.sv
      - rtl/rename_unit.sv
      - rtl/phys_reg_file.sv
      - rtl/issue_execute.sv
      - rtl/reorder_buffer.sv
      - rtl/ooo_core.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_ooo_core.sv
